/* logic/acq_defs.svh */
/*
  acq control fpga constants
  frame layout, register map, output mode codes,
  status magic and sequencer limits
*/
`ifndef ACQ_DEFS_SVH
`define ACQ_DEFS_SVH

// spi frame. write flag, address, payload
`define ACQ_DATA_W         24
`define ACQ_ADDR_W         7
`define ACQ_FRAME_W        32

//////////////////////////////
// register map
`define ACQ_REG_SPI_MUX    7'd1    // peripheral route select
`define ACQ_REG_4094       7'd2    // 4094 output enable
`define ACQ_REG_MODE       7'd3
`define ACQ_REG_DIRECT     7'd4
`define ACQ_REG_PRECHARGE  7'd5    // precharge clk count
`define ACQ_REG_SEQ_N      7'd6
`define ACQ_REG_SEQ        7'd7    // four packed entries, entry 0 low
`define ACQ_REG_APERTURE   7'd8    // mock adc aperture clk count
`define ACQ_REG_STATUS     7'd9    // read only

// output mode codes
`define ACQ_MODE_DIRECT    2'd0
`define ACQ_MODE_PATTERN   2'd1
`define ACQ_MODE_SEQ       2'd2
`define ACQ_MODE_OFF       2'd3

`define ACQ_MAGIC          8'hAA   // status low byte
`define ACQ_PATTERN_SHIFT  4       // pattern steps every 16 clk
`define ACQ_SEQ_MAX        4       // sample table depth

`endif

/* logic/acq_pkg.sv */
/*
  acq shared types
  register payload, output mode, sequence entries
  and the board output vector
*/
`include "acq_defs.svh"

package acq_pkg;

  typedef logic [`ACQ_DATA_W-1:0] data_t;   // register payload

  typedef enum logic [1:0] {
    MODE_DIRECT  = `ACQ_MODE_DIRECT,    // outputs from direct register
    MODE_PATTERN = `ACQ_MODE_PATTERN,   // free running count, board bring-up
    MODE_SEQ     = `ACQ_MODE_SEQ,       // sequencer with mock adc
    MODE_OFF     = `ACQ_MODE_OFF
  } mode_e;

  // one sample setting
  typedef struct packed {
    logic [1:0] pc_sw;    // precharge switches
    logic [3:0] azmux;    // azero mux
  } seq_entry_t;

  typedef logic [1:0] seq_idx_t;

  typedef seq_entry_t [`ACQ_SEQ_MAX-1:0] seq_tab_t;   // entry 0 in low bits

  // board outputs, leds at the low end
  typedef struct packed {
    logic       spi_interrupt;   // 18
    logic [3:0] azmux;           // 17:14
    logic [1:0] pc_sw;           // 13:12
    logic [7:0] monitor;         // 11:4
    logic [3:0] leds;            // 3:0
  } outvec_t;

endpackage

/* logic/spi_register_set.sv */
/*
  spi register set
  spi pins resampled into clk, frames shifted in msb first,
  writes committed on deselect, reads returned during the
  24 data bits of the same frame
*/
`include "acq_defs.svh"

module spi_register_set (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                sck_i,
  input  logic                ss_i,                // active low
  input  logic                sdi_i,
  input  logic [3:0]          hw_flags_i,
  input  acq_pkg::seq_idx_t   sample_idx_last_i,
  output logic                sdo_o,
  output logic [3:0]          spi_mux_o,
  output logic                oe_4094_o,
  output acq_pkg::mode_e      mode_o,
  output acq_pkg::outvec_t    direct_o,
  output acq_pkg::data_t      precharge_o,
  output logic [2:0]          seq_n_o,
  output acq_pkg::seq_tab_t   seq_o,
  output acq_pkg::data_t      aperture_o
);

  logic [2:0]              sck_q, ss_q;   // two sync stages plus edge history
  logic [1:0]              sdi_q;         // aligned with sck_q[1]
  logic                    sck_rise, sck_fall, ss_rise, sel;
  logic [`ACQ_FRAME_W-1:0] rx;            // newest bit at 0
  logic [5:0]              bit_cnt;       // rising sck this frame
  logic [`ACQ_DATA_W-2:0]  tx;            // read bits still to send
  acq_pkg::data_t          rd_data, status;
  logic                    wr;
  logic [`ACQ_ADDR_W-1:0]  wr_addr;
  acq_pkg::data_t          wr_data;

  //////////////////////////////
  // pin sync and edges

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sck_q <= '0;
      ss_q  <= '1;     // deselected
      sdi_q <= '0;
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      ss_q  <= {ss_q[1:0], ss_i};
      sdi_q <= {sdi_q[0], sdi_i};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign ss_rise  = ss_q[1] & ~ss_q[2];      // end of frame
  assign sel      = ~ss_q[1];

  //////////////////////////////
  // frame shift

  always_ff @(posedge clk) begin
    if (sel && sck_rise) begin
      rx <= {rx[`ACQ_FRAME_W-2:0], sdi_q[1]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i || !sel) begin
      bit_cnt     <= '0;
      {sdo_o, tx} <= '0;                     // miso low between frames
    end else begin
      if (sck_rise && bit_cnt != `ACQ_FRAME_W) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      if (sck_fall) begin
        // flag and address are in, load the read word
        if (bit_cnt == 6'(`ACQ_ADDR_W + 1)) begin
          {sdo_o, tx} <= rd_data;
        end else begin
          {sdo_o, tx} <= {tx, 1'b0};
        end
      end
    end
  end

  // magic, hw flags, last sample
  assign status = {10'b0, sample_idx_last_i, hw_flags_i, `ACQ_MAGIC};

  always_comb begin
    case (rx[`ACQ_ADDR_W-1:0])               // address just shifted in
      `ACQ_REG_SPI_MUX:   rd_data = acq_pkg::data_t'(spi_mux_o);
      `ACQ_REG_4094:      rd_data = acq_pkg::data_t'(oe_4094_o);
      `ACQ_REG_MODE:      rd_data = acq_pkg::data_t'(mode_o);
      `ACQ_REG_DIRECT:    rd_data = acq_pkg::data_t'(direct_o);
      `ACQ_REG_PRECHARGE: rd_data = precharge_o;
      `ACQ_REG_SEQ_N:     rd_data = acq_pkg::data_t'(seq_n_o);
      `ACQ_REG_SEQ:       rd_data = acq_pkg::data_t'(seq_o);
      `ACQ_REG_APERTURE:  rd_data = aperture_o;
      `ACQ_REG_STATUS:    rd_data = status;
      default:            rd_data = '0;      // unknown reads zero
    endcase
  end

  //////////////////////////////
  // write commit on deselect, full frames only

  assign wr      = ss_rise && (bit_cnt == `ACQ_FRAME_W) && rx[`ACQ_FRAME_W-1];
  assign wr_addr = rx[`ACQ_FRAME_W-2 -: `ACQ_ADDR_W];
  assign wr_data = rx[`ACQ_DATA_W-1:0];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      spi_mux_o   <= '0;                     // routes parked
      oe_4094_o   <= 1'b0;
      mode_o      <= acq_pkg::MODE_DIRECT;
      direct_o    <= '0;
      precharge_o <= '0;
      seq_n_o     <= '0;
      seq_o       <= '0;
      aperture_o  <= '0;
    end else if (wr) begin
      case (wr_addr)
        `ACQ_REG_SPI_MUX:   spi_mux_o   <= wr_data[3:0];
        `ACQ_REG_4094:      oe_4094_o   <= wr_data[0];
        `ACQ_REG_MODE:      mode_o      <= acq_pkg::mode_e'(wr_data[1:0]);
        `ACQ_REG_DIRECT:    direct_o    <= acq_pkg::outvec_t'(
                                             wr_data[$bits(acq_pkg::outvec_t)-1:0]);
        `ACQ_REG_PRECHARGE: precharge_o <= wr_data;
        `ACQ_REG_SEQ_N:     seq_n_o     <= wr_data[2:0];
        `ACQ_REG_SEQ:       seq_o       <= acq_pkg::seq_tab_t'(wr_data);
        `ACQ_REG_APERTURE:  aperture_o  <= wr_data;
        default: ;                           // status, unknown
      endcase
    end
  end

endmodule

/* logic/spi_periph_route.sv */
/*
  spi peripheral routing
  passes the shared spi clock and data out when a route is
  selected, steers cs2 to one chip select, parks the rest
*/
module spi_periph_route (
  input  logic [3:0] spi_mux_i,
  input  logic       sck_i,
  input  logic       sdi_i,
  input  logic       spi_cs2_i,
  output logic       glb_clk_o,
  output logic       glb_mosi_o,
  output logic       strobe_4094_o,
  output logic       dac_ss_o,
  output logic       iso_dac_cs_o,
  output logic       iso_dac_cs2_o
);

  logic parked;

  assign parked = (spi_mux_i == 4'b0000);

  // shared bus, park high when nothing routed
  assign glb_clk_o  = parked ? 1'b1 : sck_i;
  assign glb_mosi_o = parked ? 1'b1 : sdi_i;

  // 4094 strobe active high, park low
  assign strobe_4094_o = (spi_mux_i == 4'b0001) ? ~spi_cs2_i : 1'b0;

  // dac selects active low, park high
  assign dac_ss_o      = (spi_mux_i == 4'b0010) ? spi_cs2_i : 1'b1;
  assign iso_dac_cs_o  = (spi_mux_i == 4'b0100) ? spi_cs2_i : 1'b1;
  assign iso_dac_cs2_o = (spi_mux_i == 4'b1000) ? spi_cs2_i : 1'b1;

endmodule

/* logic/adc_mock.sv */
/*
  mock adc
  counts the aperture once released from reset and strobes
  a finished measurement for one clk
*/
module adc_mock (
  input  logic           clk,
  input  logic           rst_i,
  input  logic           adc_reset_n_i,
  input  acq_pkg::data_t aperture_i,
  output logic           measure_valid_o
);

  acq_pkg::data_t cnt;     // aperture clk count, starts at 1
  logic           done;    // single strobe per release

  always_ff @(posedge clk) begin
    if (rst_i || !adc_reset_n_i) begin
      cnt             <= acq_pkg::data_t'(1);
      done            <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= 1'b0;
      if (!done) begin
        // aperture 0 behaves as 1
        if (cnt >= aperture_i) begin
          measure_valid_o <= 1'b1;
          done            <= 1'b1;
        end
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

/* logic/sequence_acquisition.sv */
/*
  sequence acquisition
  precharge then measure for each programmed sample, azmux
  and pc_sw from the current entry, index wraps after seq_n
*/
module sequence_acquisition (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                trig_i,             // low holds idle
  input  logic                measure_valid_i,
  input  logic [2:0]          seq_n_i,
  input  acq_pkg::seq_tab_t   seq_i,
  input  acq_pkg::data_t      precharge_i,
  output logic                adc_reset_n_o,
  output acq_pkg::seq_idx_t   idx_o,
  output acq_pkg::seq_entry_t entry_o,
  output acq_pkg::seq_idx_t   sample_idx_last_o
);

  typedef enum logic {
    ST_PRECHARGE,            // adc held in reset
    ST_MEASURE               // adc released, wait for strobe
  } state_e;

  state_e         state;
  acq_pkg::data_t pc_cnt;     // precharge clks, starts at 1
  logic [2:0]     idx_next;   // one wider for the seq_n compare

  assign idx_next = {1'b0, idx_o} + 3'd1;

  always_ff @(posedge clk) begin
    if (rst_i || !trig_i) begin
      state  <= ST_PRECHARGE;
      pc_cnt <= acq_pkg::data_t'(1);
      idx_o  <= '0;
    end else begin
      case (state)
        ST_PRECHARGE: begin
          if (pc_cnt >= precharge_i) begin
            state <= ST_MEASURE;
          end else begin
            pc_cnt <= pc_cnt + 1'b1;
          end
        end
        ST_MEASURE: begin
          if (measure_valid_i) begin
            state  <= ST_PRECHARGE;
            pc_cnt <= acq_pkg::data_t'(1);
            // seq_n of 0 wraps like 1
            idx_o  <= (idx_next >= seq_n_i) ? 2'd0 : idx_next[1:0];
          end
        end
        default: state <= ST_PRECHARGE;
      endcase
    end
  end

  // last completed sample, kept while idle for status reads
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sample_idx_last_o <= '0;
    end else if (trig_i && state == ST_MEASURE && measure_valid_i) begin
      sample_idx_last_o <= idx_o;
    end
  end

  assign adc_reset_n_o = (state == ST_MEASURE);
  assign entry_o       = seq_i[idx_o];         // switch settings for this sample

endmodule

/* logic/output_mode_mux.sv */
/*
  output mode mux
  free running test pattern and the per mode board output
  vector, direct, pattern, sequencer or all off
*/
`include "acq_defs.svh"

module output_mode_mux (
  input  logic                clk,
  input  logic                rst_i,
  input  acq_pkg::mode_e      mode_i,
  input  acq_pkg::outvec_t    direct_i,
  input  acq_pkg::seq_idx_t   idx_i,
  input  acq_pkg::seq_entry_t entry_i,
  input  logic                adc_reset_n_i,
  input  logic                measure_valid_i,
  output acq_pkg::outvec_t    out_o
);

  localparam int OUT_W = $bits(acq_pkg::outvec_t);
  localparam int CNT_W = OUT_W + `ACQ_PATTERN_SHIFT;

  logic [CNT_W-1:0] pattern_cnt;   // low bits dropped, slows visible count
  acq_pkg::outvec_t seq_vec;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pattern_cnt <= '0;
    end else begin
      pattern_cnt <= pattern_cnt + 1'b1;
    end
  end

  // sequencer view
  always_comb begin
    seq_vec               = '0;
    seq_vec.leds          = 4'b0001 << idx_i;   // one-hot sample
    seq_vec.monitor[0]    = adc_reset_n_i;
    seq_vec.monitor[1]    = measure_valid_i;
    seq_vec.monitor[3:2]  = idx_i;
    seq_vec.pc_sw         = entry_i.pc_sw;
    seq_vec.azmux         = entry_i.azmux;
    seq_vec.spi_interrupt = measure_valid_i;    // mcu picks up the sample
  end

  always_comb begin
    case (mode_i)
      acq_pkg::MODE_DIRECT:  out_o = direct_i;
      acq_pkg::MODE_PATTERN: out_o = acq_pkg::outvec_t'(
                                       pattern_cnt[CNT_W-1:`ACQ_PATTERN_SHIFT]);
      acq_pkg::MODE_SEQ:     out_o = seq_vec;
      default:               out_o = '0;         // off
    endcase
  end

endmodule

/* logic/acq_top.sv */
/*
  acq control fpga top
  register set, spi peripheral routing, sequencer paced by
  the mock adc, and the output mode mux onto the board pins
*/
module acq_top (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       sck_i,
  input  logic       ss_i,
  input  logic       sdi_i,
  input  logic       spi_cs2_i,
  input  logic [3:0] hw_flags_i,
  input  logic       trig_sa_i,
  output logic       sdo_o,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic       spi_interrupt_o,
  output logic       oe_4094_o,
  output logic       glb_clk_o,
  output logic       glb_mosi_o,
  output logic       strobe_4094_o,
  output logic       dac_ss_o,
  output logic       iso_dac_cs_o,
  output logic       iso_dac_cs2_o
);

  logic [3:0]          reg_spi_mux;
  acq_pkg::mode_e      reg_mode;
  acq_pkg::outvec_t    reg_direct;
  acq_pkg::data_t      reg_precharge, reg_aperture;
  logic [2:0]          reg_seq_n;
  acq_pkg::seq_tab_t   reg_seq;
  logic                adc_reset_n, measure_valid;
  acq_pkg::seq_idx_t   seq_idx, sample_idx_last;
  acq_pkg::seq_entry_t seq_entry;
  acq_pkg::outvec_t    out_vec;

  spi_register_set u_regs (
    .clk(clk), .rst_i(rst_i),
    .sck_i(sck_i), .ss_i(ss_i), .sdi_i(sdi_i),
    .hw_flags_i(hw_flags_i), .sample_idx_last_i(sample_idx_last),
    .sdo_o(sdo_o), .spi_mux_o(reg_spi_mux), .oe_4094_o(oe_4094_o),
    .mode_o(reg_mode), .direct_o(reg_direct), .precharge_o(reg_precharge),
    .seq_n_o(reg_seq_n), .seq_o(reg_seq), .aperture_o(reg_aperture)
  );

  spi_periph_route u_route (
    .spi_mux_i(reg_spi_mux), .sck_i(sck_i), .sdi_i(sdi_i), .spi_cs2_i(spi_cs2_i),
    .glb_clk_o(glb_clk_o), .glb_mosi_o(glb_mosi_o), .strobe_4094_o(strobe_4094_o),
    .dac_ss_o(dac_ss_o), .iso_dac_cs_o(iso_dac_cs_o), .iso_dac_cs2_o(iso_dac_cs2_o)
  );

  //////////////////////////////
  // sequencer paced by mock adc

  adc_mock u_adc (
    .clk(clk), .rst_i(rst_i),
    .adc_reset_n_i(adc_reset_n), .aperture_i(reg_aperture),
    .measure_valid_o(measure_valid)
  );

  sequence_acquisition u_seq (
    .clk(clk), .rst_i(rst_i), .trig_i(trig_sa_i),
    .measure_valid_i(measure_valid),                 // from mock adc
    .seq_n_i(reg_seq_n), .seq_i(reg_seq), .precharge_i(reg_precharge),
    .adc_reset_n_o(adc_reset_n), .idx_o(seq_idx), .entry_o(seq_entry),
    .sample_idx_last_o(sample_idx_last)              // back to status
  );

  output_mode_mux u_mux (
    .clk(clk), .rst_i(rst_i), .mode_i(reg_mode), .direct_i(reg_direct),
    .idx_i(seq_idx), .entry_i(seq_entry),
    .adc_reset_n_i(adc_reset_n), .measure_valid_i(measure_valid),
    .out_o(out_vec)
  );

  // pin groups
  assign leds_o          = out_vec.leds;
  assign monitor_o       = out_vec.monitor;
  assign pc_sw_o         = out_vec.pc_sw;
  assign azmux_o         = out_vec.azmux;
  assign spi_interrupt_o = out_vec.spi_interrupt;

endmodule

/* test/tb_clock.sv */
/*
  testbench clock and reset
  20 ns clock, reset held across the first two rising edges
*/
module tb_clock (
  output logic clk_o,
  output logic rst_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;   // 50 MHz crystal
  end

  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;                 // release on a falling edge like other inputs
  end

endmodule

/* test/acq_properties.sv */
/*
  acq top properties
  reset state, spi routing, pattern steps and sequencer
  pulses, checked at the board pins of acq_top
*/
module acq_properties (
  input logic           clk,
  input logic           rst_i,
  input logic           sck_i,
  input logic           sdi_i,
  input logic           spi_cs2_i,
  input logic           trig_i,
  input logic [3:0]     spi_mux_i,
  input acq_pkg::mode_e mode_i,
  input logic [2:0]     seq_n_i,
  input logic [23:0]    seq_i,       // entry 0 in low bits
  input logic [18:0]    pins_i,      // board output vector
  input logic [5:0]     route_i      // glb_clk, glb_mosi, strobe, dac, iso, iso2
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;   // polled by tb_top
  logic        seq_pulse;
  logic [5:0]  exp_route;
  logic [1:0]  exp_idx;        // sample the next pulse belongs to
  logic [2:0]  exp_next;
  logic [5:0]  exp_entry;      // {pc_sw, azmux}
  logic [18:0] pins_q;
  logic        pattern_q;

  assign seq_pulse = (mode_i == acq_pkg::MODE_SEQ) && pins_i[18];

  // idle levels, dacs active low, 4094 strobe active high
  assign exp_route = {
    (spi_mux_i == 4'd0) ? 1'b1 : sck_i,
    (spi_mux_i == 4'd0) ? 1'b1 : sdi_i,
    (spi_mux_i == 4'd1) ? ~spi_cs2_i : 1'b0,
    (spi_mux_i == 4'd2) ? spi_cs2_i : 1'b1,
    (spi_mux_i == 4'd4) ? spi_cs2_i : 1'b1,
    (spi_mux_i == 4'd8) ? spi_cs2_i : 1'b1
  };

  assign exp_next  = {1'b0, exp_idx} + 3'd1;
  assign exp_entry = seq_i[6*exp_idx +: 6];

  //////////////////////////////
  // reference state

  always_ff @(posedge clk) begin
    if (rst_i || !trig_i) begin
      exp_idx <= '0;                                       // sequencer restarts at 0
    end else if (seq_pulse) begin
      exp_idx <= (exp_next >= seq_n_i) ? 2'd0 : exp_next[1:0];   // n of 0 acts as 1
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pins_q    <= '0;
      pattern_q <= 1'b0;
    end else begin
      pins_q    <= pins_i;
      pattern_q <= (mode_i == acq_pkg::MODE_PATTERN);
    end
  end

  //////////////////////////////
  // properties

  a_reset_state: assert property (@(posedge clk)
    $fell(rst_i) |-> (pins_i == '0 && route_i == 6'b110111))
  else begin
    $error("** Error at %0t: pins 0x%0h route %b after reset, expected 0x0 and 110111",
           $time, $sampled(pins_i), $sampled(route_i));
    fail_cnt++;
  end

  a_route: assert property (@(posedge clk) disable iff (rst_i)
    route_i == exp_route)
  else begin
    $error("** Error at %0t: route outputs %b, expected %b (spi_mux %0d)",
           $time, $sampled(route_i), $sampled(exp_route), $sampled(spi_mux_i));
    fail_cnt++;
  end

  a_pattern_step: assert property (@(posedge clk) disable iff (rst_i)
    (pattern_q && mode_i == acq_pkg::MODE_PATTERN) |-> ((pins_i - pins_q) <= 19'd1))
  else begin
    $error("** Error at %0t: pattern pins 0x%0h, expected 0x%0h or one more",
           $time, $sampled(pins_i), $sampled(pins_q));
    fail_cnt++;
  end

  a_pulse_width: assert property (@(posedge clk) disable iff (rst_i)
    seq_pulse |=> !pins_i[18])
  else begin
    $error("** Error at %0t: spi_interrupt_o stayed high longer than one cycle", $time);
    fail_cnt++;
  end

  a_seq_entry: assert property (@(posedge clk) disable iff (rst_i)
    seq_pulse |-> ({pins_i[13:12], pins_i[17:14]} == exp_entry
                   && pins_i[3:0] == (4'b0001 << exp_idx)))
  else begin
    $error("** Error at %0t: pc_sw/azmux %b leds %b, expected %b and sample %0d",
           $time, $sampled({pins_i[13:12], pins_i[17:14]}), $sampled(pins_i[3:0]),
           $sampled(exp_entry), $sampled(exp_idx));
    fail_cnt++;
  end

endmodule

bind acq_top acq_properties u_props (
  .clk(clk), .rst_i(rst_i), .sck_i(sck_i), .sdi_i(sdi_i), .spi_cs2_i(spi_cs2_i),
  .trig_i(trig_sa_i), .spi_mux_i(reg_spi_mux), .mode_i(reg_mode),
  .seq_n_i(reg_seq_n), .seq_i(reg_seq),
  .pins_i({spi_interrupt_o, azmux_o, pc_sw_o, monitor_o, leds_o}),
  .route_i({glb_clk_o, glb_mosi_o, strobe_4094_o, dac_ss_o, iso_dac_cs_o, iso_dac_cs2_o})
);

/* test/tb_top.sv */
/*
  acq control fpga testbench
  spi frames into the register set, then reset, status, direct,
  routing, pattern and sequencer runs, one line per test
*/
`include "acq_defs.svh"

module tb_top;

  timeunit 1ns;
  timeprecision 1ps;

  // entries 3..0, {pc_sw, azmux} each
  localparam logic [23:0] seq_table = {6'h0e, 6'h39, 6'h25, 6'h13};

  logic        clk, rst;
  logic        sck_i, ss_i, sdi_i, spi_cs2_i, trig_sa_i;
  logic [3:0]  hw_flags_i;
  logic        sdo_o, spi_interrupt_o, oe_4094_o;
  logic [3:0]  leds_o, azmux_o;
  logic [7:0]  monitor_o;
  logic [1:0]  pc_sw_o;
  logic        glb_clk_o, glb_mosi_o, strobe_4094_o, dac_ss_o, iso_dac_cs_o, iso_dac_cs2_o;
  logic [18:0] pins;
  logic [5:0]  route;
  logic [31:0] lfsr_state = 32'he4e1_28db;
  int          tb_errors = 0;
  int          mark = 0;      // error total at test start
  int          tests_run = 0;
  int          tests_failed = 0;

  tb_clock u_clk (.clk_o(clk), .rst_o(rst));

  acq_top i_dut (
    .clk(clk), .rst_i(rst), .sck_i(sck_i), .ss_i(ss_i), .sdi_i(sdi_i),
    .spi_cs2_i(spi_cs2_i), .hw_flags_i(hw_flags_i), .trig_sa_i(trig_sa_i),
    .sdo_o(sdo_o), .leds_o(leds_o), .monitor_o(monitor_o), .pc_sw_o(pc_sw_o),
    .azmux_o(azmux_o), .spi_interrupt_o(spi_interrupt_o), .oe_4094_o(oe_4094_o),
    .glb_clk_o(glb_clk_o), .glb_mosi_o(glb_mosi_o), .strobe_4094_o(strobe_4094_o),
    .dac_ss_o(dac_ss_o), .iso_dac_cs_o(iso_dac_cs_o), .iso_dac_cs2_o(iso_dac_cs2_o)
  );

  assign pins  = {spi_interrupt_o, azmux_o, pc_sw_o, monitor_o, leds_o};
  assign route = {glb_clk_o, glb_mosi_o, strobe_4094_o, dac_ss_o, iso_dac_cs_o, iso_dac_cs2_o};

  //////////////////////////////
  // helpers

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [23:0] random_bits(input int n);
    logic [23:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[22:0], lfsr_bit()};       // one step per bit
    end
    return v;
  endfunction

  function automatic int total_errors();
    return tb_errors + int'(i_dut.u_props.fail_cnt);
  endfunction

  task automatic check_value(input string name, input logic [23:0] got,
                             input logic [23:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      tb_errors++;
    end
  endtask

  task automatic begin_test();
    mark = total_errors();
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = total_errors() - mark;
    tests_run++;
    if (errs == 0) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errs);
    end
  endtask

  // one full frame, each sck level held 4 clk, miso sampled before each rise
  task automatic spi_frame(input logic [31:0] frame, output logic [23:0] miso);
    miso = '0;
    repeat (6) @(negedge clk);           // gap after the previous deselect
    ss_i = 1'b0;
    repeat (4) @(negedge clk);
    for (int i = `ACQ_FRAME_W - 1; i >= 0; i--) begin
      sdi_i = frame[i];
      repeat (4) @(negedge clk);
      if (i < `ACQ_DATA_W) begin
        miso[i] = sdo_o;
      end
      sck_i = 1'b1;
      repeat (4) @(negedge clk);
      sck_i = 1'b0;
    end
    repeat (4) @(negedge clk);
    ss_i = 1'b1;                         // write commits here
  endtask

  task automatic write_reg(input logic [6:0] addr, input logic [23:0] data);
    logic [23:0] discard;
    spi_frame({1'b1, addr, data}, discard);
  endtask

  task automatic read_reg(input logic [6:0] addr, output logic [23:0] data);
    spi_frame({1'b0, addr, 24'h0}, data);
  endtask

  task automatic wait_pins(input logic [18:0] exp, input int limit);
    int n;
    n = 0;
    while (pins !== exp && n < limit) begin
      @(negedge clk);
      n++;
    end
    check_value("output pins", 24'(pins), 24'(exp));
  endtask

  task automatic wait_interrupt(input int limit);
    int n;
    n = 0;
    @(negedge clk);                      // step past the previous pulse
    while (!spi_interrupt_o && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!spi_interrupt_o) begin
      $display("timeout at %0t ns waiting for a sequencer interrupt", $time);
      tb_errors++;
    end
  endtask

  //////////////////////////////
  // stimulus

  initial begin
    logic [23:0] rd, rnd;
    logic [18:0] last;
    logic [3:0]  mux;
    int          n, changes;

    sck_i      = 1'b0;
    ss_i       = 1'b1;
    sdi_i      = 1'b0;
    spi_cs2_i  = 1'b1;
    hw_flags_i = 4'h0;
    trig_sa_i  = 1'b0;

    n = 0;
    while (rst !== 1'b0 && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      $display("reset was never released by %0t ns", $time);
      tb_errors++;
    end

    begin_test();
    @(negedge clk);
    check_value("output pins", 24'(pins), 24'h0);
    check_value("route outputs", 24'(route), 24'h37);   // clk, mosi high, dacs high
    check_value("sdo_o", 24'(sdo_o), 24'h0);
    check_value("oe_4094_o", 24'(oe_4094_o), 24'h0);
    report_test("reset");

    begin_test();
    repeat (2) begin
      rnd        = random_bits(4);
      hw_flags_i = rnd[3:0];
      read_reg(`ACQ_REG_STATUS, rd);
      check_value("status magic", 24'(rd[7:0]), 24'(`ACQ_MAGIC));
      check_value("status hw_flags", 24'(rd[11:8]), 24'(rnd[3:0]));
    end
    report_test("status");

    begin_test();
    repeat (3) begin
      rnd = random_bits(19);
      write_reg(`ACQ_REG_DIRECT, rnd);
      wait_pins(rnd[18:0], 5);           // visible within 5 clk of deselect
      read_reg(`ACQ_REG_DIRECT, rd);
      check_value("direct register", rd, rnd);
    end
    report_test("direct");

    begin_test();
    for (int k = 0; k < 5; k++) begin
      mux = (k == 0) ? 4'd0 : 4'(1 << (k - 1));
      write_reg(`ACQ_REG_SPI_MUX, 24'(mux));
      for (int j = 0; j < 8; j++) begin
        {sdi_i, sck_i, spi_cs2_i} = 3'(j);   // all pin combinations
        repeat (2) @(negedge clk);
      end
      {sdi_i, sck_i, spi_cs2_i} = 3'b001;
      read_reg(`ACQ_REG_SPI_MUX, rd);
      check_value("spi_mux register", rd, 24'(mux));
    end
    write_reg(`ACQ_REG_4094, 24'h1);
    repeat (5) @(negedge clk);           // register visible within 5 clk
    check_value("oe_4094_o", 24'(oe_4094_o), 24'h1);
    read_reg(`ACQ_REG_4094, rd);
    check_value("4094 register", rd, 24'h1);
    report_test("routing");

    begin_test();
    write_reg(`ACQ_REG_MODE, 24'(`ACQ_MODE_PATTERN));
    changes = 0;
    n       = 0;
    last    = pins;
    while (changes < 4 && n < 200) begin
      @(negedge clk);
      n++;
      if (pins !== last) begin
        changes++;
        last = pins;
      end
    end
    if (changes < 4) begin
      $display("pattern output stalled after %0d steps at %0t ns", changes, $time);
      tb_errors++;
    end
    report_test("pattern");

    begin_test();
    write_reg(`ACQ_REG_PRECHARGE, 24'd3);
    write_reg(`ACQ_REG_APERTURE, 24'd5);
    write_reg(`ACQ_REG_SEQ, seq_table);
    write_reg(`ACQ_REG_SEQ_N, 24'd3);
    write_reg(`ACQ_REG_MODE, 24'(`ACQ_MODE_SEQ));
    repeat (5) @(negedge clk);           // mode commit
    trig_sa_i = 1'b1;
    repeat (7) wait_interrupt(40);       // wraps twice over three samples
    read_reg(`ACQ_REG_STATUS, rd);
    assert (rd[13:12] < 2'd3) else begin
      $display("** Error at %0t ns: sample_idx_last is %0d, expected below 3",
               $time, rd[13:12]);
      tb_errors++;
    end
    trig_sa_i = 1'b0;
    write_reg(`ACQ_REG_SEQ_N, 24'd0);    // single sample
    trig_sa_i = 1'b1;
    repeat (3) wait_interrupt(40);
    trig_sa_i = 1'b0;
    write_reg(`ACQ_REG_MODE, 24'(`ACQ_MODE_OFF));
    wait_pins(19'h0, 5);
    report_test("sequence");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+logic
logic/acq_pkg.sv
logic/spi_register_set.sv
logic/spi_periph_route.sv
logic/adc_mock.sv
logic/sequence_acquisition.sv
logic/output_mode_mux.sv
logic/acq_top.sv
test/tb_clock.sv
test/acq_properties.sv
test/tb_top.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP   = tb_top
FLIST = all.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; \
	status=$$?; cat $(LOG); exit $$status
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
